/* project.f */
xif_pkg.sv
xif_predecoder.sv
xif_instr_queue.sv
xif_alu_unit.sv
xif_acc_wrapper.sv
tb_xif_checker.sv
tb_xif_acc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_xif_acc \
  -f project.f \
  --Mdir obj_dir \
  -o tb_xif_acc

./obj_dir/tb_xif_acc > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tb_xif_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_xif_acc
  import xif_pkg::*;
();

  localparam int unsigned NumRequests   = 400;
  localparam int unsigned TimeoutCycles = NumRequests * 20;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned QueueDepth    = 4;
  localparam logic [31:0] Seed          = 32'h505236ac;

  logic             clk;
  logic             rst_n;
  logic             q_valid;
  logic             q_ready;
  logic [31:0]      q_instr;
  logic [2:0][31:0] q_rs;
  logic [2:0]       q_rs_valid;
  logic             k_accept;
  logic             k_writeback;
  logic             p_valid;
  logic             p_ready;
  logic [4:0]       p_rd;
  logic [31:0]      p_data;

  logic [31:0] lfsr;
  int unsigned cycle_cnt = 0;
  int unsigned stall_left;
  int unsigned end_errors;
  int unsigned error_count;
  int unsigned accept_count;
  int unsigned response_count;
  int unsigned late_count;

  xif_acc_wrapper #(
    .QueueDepth(QueueDepth)
  ) u_xif_acc_wrapper (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .x_q_valid_i     (q_valid),
    .x_q_ready_o     (q_ready),
    .x_q_instr_data_i(q_instr),
    .x_q_rs_i        (q_rs),
    .x_q_rs_valid_i  (q_rs_valid),
    .x_k_accept_o    (k_accept),
    .x_k_writeback_o (k_writeback),
    .x_p_valid_o     (p_valid),
    .x_p_ready_i     (p_ready),
    .x_p_rd_o        (p_rd),
    .x_p_data_o      (p_data)
  );

  tb_xif_checker #(
    .QueueDepth(QueueDepth)
  ) u_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .x_q_valid_i     (q_valid),
    .x_q_ready_i     (q_ready),
    .x_q_instr_data_i(q_instr),
    .x_q_rs_i        (q_rs),
    .x_q_rs_valid_i  (q_rs_valid),
    .x_k_accept_i    (k_accept),
    .x_k_writeback_i (k_writeback),
    .x_p_valid_i     (p_valid),
    .x_p_ready_i     (p_ready),
    .x_p_rd_i        (p_rd),
    .x_p_data_i      (p_data),
    .error_count_o   (error_count),
    .accept_count_o  (accept_count),
    .response_count_o(response_count),
    .late_count_o    (late_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] value);
    int unsigned k;
    value = 32'h0;
    for (k = 0; k < n; k++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // Short random gaps plus an occasional long stall of the response channel
  task automatic update_ready();
    logic [31:0] r;
    take_bits(5, r);
    if (stall_left != 0) begin
      p_ready    = 1'b0;
      stall_left = stall_left - 1;
    end else if (r[4:0] == 5'd0) begin
      p_ready    = 1'b0;
      stall_left = 24;
    end else begin
      p_ready = (r[1:0] != 2'b00);
    end
  endtask

  task automatic send_request();
    logic [31:0] r;
    logic [31:0] instr;
    logic        handshake;
    int unsigned k;
    take_bits(2, r);
    take_bits(32, instr);
    if (r[1:0] != 2'b00) instr[6:0] = OPCODE_CUSTOM0;
    q_instr = instr;
    for (k = 0; k < 3; k++) begin
      take_bits(32, r);
      q_rs[k] = r;
    end
    take_bits(3, r);
    q_rs_valid = r[2:0];
    q_valid    = 1'b1;
    handshake  = 1'b0;
    while (!handshake) begin
      @(posedge clk);
      handshake = q_ready;
      @(negedge clk);
      update_ready();
      // Missing operands arrive late, a few bits per cycle
      if (!handshake) begin
        take_bits(3, r);
        q_rs_valid = q_rs_valid | r[2:0];
      end
    end
    q_valid = 1'b0;
    take_bits(2, r);
    if (r[1:0] == 2'b00) begin
      @(negedge clk);
      update_ready();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    q_valid    = 1'b0;
    q_instr    = 32'h0;
    q_rs       = '0;
    q_rs_valid = 3'b000;
    p_ready    = 1'b0;
    lfsr       = Seed;
    stall_left = 0;
    end_errors = 0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n   = 1'b1;
    p_ready = 1'b1;
    // Idle window, the DUT must stay silent
    repeat (10) @(negedge clk);
    for (int unsigned n = 0; n < NumRequests; n++) begin
      send_request();
    end
    while (response_count < accept_count) begin
      @(negedge clk);
      update_ready();
    end
    p_ready = 1'b1;
    repeat (10) @(negedge clk);
    if (response_count != accept_count) begin
      $display("Response count %0d does not match accepted count %0d",
               response_count, accept_count);
      end_errors++;
    end
    if (late_count == 0) begin
      $display("No accepted instruction completed after waiting for a late operand");
      end_errors++;
    end
    $display("Run done: %0d requests, %0d accepted, %0d responses, %0d late, %0d errors",
             NumRequests, accept_count, response_count, late_count, error_count + end_errors);
    if (error_count == 0 && end_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_xif_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_xif_checker #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             x_q_valid_i,
  input  logic             x_q_ready_i,
  input  logic [31:0]      x_q_instr_data_i,
  input  logic [2:0][31:0] x_q_rs_i,
  input  logic [2:0]       x_q_rs_valid_i,
  input  logic             x_k_accept_i,
  input  logic             x_k_writeback_i,
  input  logic             x_p_valid_i,
  input  logic             x_p_ready_i,
  input  logic [4:0]       x_p_rd_i,
  input  logic [31:0]      x_p_data_i,
  output int unsigned      error_count_o,
  output int unsigned      accept_count_o,
  output int unsigned      response_count_o,
  output int unsigned      late_count_o
);

  localparam logic [6:0] Custom0 = 7'b0001011;

  logic [31:0] exp_data_q[$];
  logic [4:0]  exp_rd_q[$];
  logic        hold_q = 1'b0;
  logic [4:0]  held_rd;
  logic [31:0] held_data;
  logic        waiting_on_rs = 1'b0;
  logic        run_started = 1'b0;
  logic        exp_accept;
  logic        exp_ready;
  logic [2:0]  missing;
  logic [31:0] exp_data;
  logic [4:0]  exp_rd;
  int          queued;

  initial begin
    error_count_o    = 0;
    accept_count_o   = 0;
    response_count_o = 0;
    late_count_o     = 0;
  end

  // One bit at a time, so the amount is applied as a plain repeat count
  function automatic logic [31:0] rotate_left(input logic [31:0] value, input logic [4:0] amount);
    logic [31:0] r;
    int          k;
    r = value;
    for (k = 0; k < 32; k++) begin
      if (k < int'(amount)) begin
        r = {r[30:0], r[31]};
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_result(input logic [31:0] instr, input logic [31:0] a,
                                                  input logic [31:0] b, input logic [31:0] c);
    logic [31:0] res;
    case (instr[14:12])
      3'd0:    res = a + b + c;
      3'd1:    res = ($signed(a) < $signed(b)) ? a : b;
      3'd2:    res = ($signed(a) > $signed(b)) ? a : b;
      3'd3:    res = rotate_left(a, b[4:0]);
      3'd4:    res = rotate_left(a, instr[24:20]);
      default: res = 32'h0;
    endcase
    return res;
  endfunction

  function automatic logic accept_rule(input logic [31:0] instr);
    return (instr[6:0] == Custom0) && (instr[14:12] <= 3'd4);
  endfunction

  // Operands each operation reads, rs3 in the top bit
  function automatic logic [2:0] needed_operands(input logic [31:0] instr);
    logic [2:0] m;
    case (instr[14:12])
      3'd0:             m = 3'b111;
      3'd1, 3'd2, 3'd3: m = 3'b011;
      3'd4:             m = 3'b001;
      default:          m = 3'b000;
    endcase
    return m;
  endfunction

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("Error at %0t: %s expected 0x%h got 0x%h", $time, name, expected, actual);
    error_count_o++;
  endtask

  // Values seen here are the ones settled before this clock edge
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_q        = 1'b0;
      waiting_on_rs = 1'b0;
      run_started   = 1'b0;
    end else begin
      if (!run_started) begin
        run_started = 1'b1;
        if (x_p_valid_i !== 1'b0) value_error("x_p_valid_o", 32'h0, 32'(x_p_valid_i));
      end

      // Entries in flight sit in the queue or in the one-entry output stage
      queued = int'(accept_count_o) - int'(response_count_o) - (x_p_valid_i ? 1 : 0);

      // Request side
      if (x_q_valid_i) begin
        missing    = needed_operands(x_q_instr_data_i) & ~x_q_rs_valid_i;
        exp_accept = accept_rule(x_q_instr_data_i);
        exp_ready  = !exp_accept || (missing == 3'b000 && queued < int'(QueueDepth));
        if (x_q_ready_i !== exp_ready) begin
          value_error("x_q_ready_o", 32'(exp_ready), 32'(x_q_ready_i));
        end
      end
      if (x_q_valid_i && x_q_ready_i) begin
        if (x_k_accept_i !== exp_accept) begin
          value_error("x_k_accept_o", 32'(exp_accept), 32'(x_k_accept_i));
        end
        if (x_k_writeback_i !== exp_accept) begin
          value_error("x_k_writeback_o", 32'(exp_accept), 32'(x_k_writeback_i));
        end
        if (exp_accept) begin
          exp_data_q.push_back(expected_result(x_q_instr_data_i, x_q_rs_i[0], x_q_rs_i[1],
                                               x_q_rs_i[2]));
          exp_rd_q.push_back(x_q_instr_data_i[11:7]);
          accept_count_o++;
          if (waiting_on_rs) late_count_o++;
        end
        waiting_on_rs = 1'b0;
      end else if (x_q_valid_i && exp_accept && (missing != 3'b000)) begin
        waiting_on_rs = 1'b1;
      end

      // A stalled response must hold its payload
      if (hold_q) begin
        if (x_p_valid_i !== 1'b1) value_error("x_p_valid_o", 32'h1, 32'(x_p_valid_i));
        if (x_p_rd_i !== held_rd) value_error("x_p_rd_o", 32'(held_rd), 32'(x_p_rd_i));
        if (x_p_data_i !== held_data) value_error("x_p_data_o", held_data, x_p_data_i);
      end
      hold_q    = x_p_valid_i && !x_p_ready_i;
      held_rd   = x_p_rd_i;
      held_data = x_p_data_i;

      // Response side, in acceptance order
      if (x_p_valid_i && x_p_ready_i) begin
        response_count_o++;
        if (exp_data_q.size() == 0) begin
          $display("Error at %0t: a response with rd %0d arrived while nothing was pending",
                   $time, x_p_rd_i);
          error_count_o++;
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_rd   = exp_rd_q.pop_front();
          if (x_p_data_i !== exp_data) value_error("x_p_data_o", exp_data, x_p_data_i);
          if (x_p_rd_i !== exp_rd) value_error("x_p_rd_o", 32'(exp_rd), 32'(x_p_rd_i));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* xif_acc_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module xif_acc_wrapper
  import xif_pkg::*;
#(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // X-request channel
  input  logic                      x_q_valid_i,
  output logic                      x_q_ready_o,
  input  logic [InstrWidth-1:0]     x_q_instr_data_i,
  input  logic [2:0][DataWidth-1:0] x_q_rs_i,
  input  logic [2:0]                x_q_rs_valid_i,
  output logic                      x_k_accept_o,
  output logic                      x_k_writeback_o,

  // X-response channel
  output logic                      x_p_valid_o,
  input  logic                      x_p_ready_i,
  output logic [4:0]                x_p_rd_o,
  output logic [DataWidth-1:0]      x_p_data_o
);

  // Predecoder to queue
  logic                      push_valid;
  logic [InstrWidth-1:0]     push_instr;
  logic [2:0][DataWidth-1:0] push_rs;
  logic                      full;

  // Queue to accelerator
  logic                      pop_valid;
  logic                      pop_ready;
  logic [InstrWidth-1:0]     pop_instr;
  logic [2:0][DataWidth-1:0] pop_rs;

  xif_predecoder u_predecoder (
    .x_q_valid_i     (x_q_valid_i),
    .x_q_ready_o     (x_q_ready_o),
    .x_q_instr_data_i(x_q_instr_data_i),
    .x_q_rs_i        (x_q_rs_i),
    .x_q_rs_valid_i  (x_q_rs_valid_i),
    .x_k_accept_o    (x_k_accept_o),
    .x_k_writeback_o (x_k_writeback_o),
    .full_i          (full),
    .push_valid_o    (push_valid),
    .push_instr_o    (push_instr),
    .push_rs_o       (push_rs)
  );

  xif_instr_queue #(
    .Depth(QueueDepth)
  ) u_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_valid_i(push_valid),
    .push_instr_i(push_instr),
    .push_rs_i   (push_rs),
    .full_o      (full),
    .pop_valid_o (pop_valid),
    .pop_ready_i (pop_ready),
    .pop_instr_o (pop_instr),
    .pop_rs_o    (pop_rs)
  );

  xif_alu_unit u_alu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pop_valid_i(pop_valid),
    .pop_ready_o(pop_ready),
    .pop_instr_i(pop_instr),
    .pop_rs_i   (pop_rs),
    .x_p_valid_o(x_p_valid_o),
    .x_p_ready_i(x_p_ready_i),
    .x_p_rd_o   (x_p_rd_o),
    .x_p_data_o (x_p_data_o)
  );

endmodule

`default_nettype wire

/* xif_alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module xif_alu_unit
  import xif_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // Head of the instruction queue
  input  logic                      pop_valid_i,
  output logic                      pop_ready_o,
  input  logic [InstrWidth-1:0]     pop_instr_i,
  input  logic [2:0][DataWidth-1:0] pop_rs_i,

  // X-response channel to the core
  output logic                      x_p_valid_o,
  input  logic                      x_p_ready_i,
  output logic [4:0]                x_p_rd_o,
  output logic [DataWidth-1:0]      x_p_data_o
);

  localparam int unsigned ShWidth = $clog2(DataWidth);

  xinstr_u              instr;
  logic [DataWidth-1:0] rs1;
  logic [DataWidth-1:0] rs2;
  logic [DataWidth-1:0] rs3;
  logic [DataWidth-1:0] result;
  logic                 pop_en;

  logic                 out_valid_q;
  logic [4:0]           out_rd_q;
  logic [DataWidth-1:0] out_data_q;

  // Rotate by doubling the word, the upper half is the result
  function automatic logic [DataWidth-1:0] rotl(input logic [DataWidth-1:0] a,
                                                input logic [ShWidth-1:0]   sh);
    logic [2*DataWidth-1:0] dbl;
    dbl = {a, a} << sh;
    return dbl[2*DataWidth-1 -: DataWidth];
  endfunction

  assign instr = pop_instr_i;
  assign rs1   = pop_rs_i[0];
  assign rs2   = pop_rs_i[1];
  assign rs3   = pop_rs_i[2];

  always_comb begin
    case (instr.r4.funct3)
      FUNCT3_ADD3: result = rs1 + rs2 + rs3;
      FUNCT3_MIN:  result = ($signed(rs1) < $signed(rs2)) ? rs1 : rs2;
      FUNCT3_MAX:  result = ($signed(rs1) < $signed(rs2)) ? rs2 : rs1;
      FUNCT3_ROL:  result = rotl(rs1, rs2[ShWidth-1:0]);
      // Shift amount from the I-format immediate
      FUNCT3_ROLI: result = rotl(rs1, instr.i.imm12[ShWidth-1:0]);
      default:     result = '0;
    endcase
  end

  // Take a new entry when the output stage is empty or draining now
  assign pop_ready_o = ~out_valid_q | x_p_ready_i;
  assign pop_en      = pop_valid_i & pop_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (pop_en) begin
      out_valid_q <= 1'b1;
    end else if (x_p_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload only moves on a pop, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (pop_en) begin
      out_rd_q   <= instr.r4.rd;
      out_data_q <= result;
    end
  end

  assign x_p_valid_o = out_valid_q;
  assign x_p_rd_o    = out_rd_q;
  assign x_p_data_o  = out_data_q;

endmodule

`default_nettype wire

/* xif_instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module xif_instr_queue
  import xif_pkg::*;
#(
  parameter int unsigned Depth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // Write side, fed by the predecoder
  input  logic                      push_valid_i,
  input  logic [InstrWidth-1:0]     push_instr_i,
  input  logic [2:0][DataWidth-1:0] push_rs_i,
  output logic                      full_o,

  // Read side, drained by the accelerator
  output logic                      pop_valid_o,
  input  logic                      pop_ready_i,
  output logic [InstrWidth-1:0]     pop_instr_o,
  output logic [2:0][DataWidth-1:0] pop_rs_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [EntryWidth-1:0] mem_q [Depth];
  logic [EntryWidth-1:0] head_entry;
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push_en;
  logic                  pop_en;

  // Pointer advance with explicit wrap, so any depth works
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    logic [PtrWidth-1:0] nxt;
    if (ptr == PtrWidth'(Depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full_o      = (count_q == CntWidth'(Depth));
  assign pop_valid_o = (count_q != '0);
  assign push_en     = push_valid_i & ~full_o;
  assign pop_en      = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= {push_instr_i, push_rs_i};
    end
  end

  assign head_entry  = mem_q[rd_ptr_q];
  assign pop_instr_o = head_entry[EntryWidth-1 -: InstrWidth];
  assign pop_rs_o    = head_entry[3*DataWidth-1:0];

endmodule

`default_nettype wire

/* xif_predecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module xif_predecoder
  import xif_pkg::*;
(
  // X-request channel from the core
  input  logic                      x_q_valid_i,
  output logic                      x_q_ready_o,
  input  logic [InstrWidth-1:0]     x_q_instr_data_i,
  input  logic [2:0][DataWidth-1:0] x_q_rs_i,
  input  logic [2:0]                x_q_rs_valid_i,
  output logic                      x_k_accept_o,
  output logic                      x_k_writeback_o,

  // Push side of the instruction queue
  input  logic                      full_i,
  output logic                      push_valid_o,
  output logic [InstrWidth-1:0]     push_instr_o,
  output logic [2:0][DataWidth-1:0] push_rs_o
);

  xinstr_u    instr;
  logic       accept;
  logic [2:0] rs_needed;
  logic       operands_ready;
  logic       can_push;

  assign instr = x_q_instr_data_i;

  // Decode opcode and funct3, build the mask of operands the op reads
  always_comb begin
    accept    = 1'b0;
    rs_needed = 3'b000;
    if (instr.r4.opcode == OPCODE_CUSTOM0) begin
      case (instr.r4.funct3)
        FUNCT3_ADD3: begin
          accept    = 1'b1;
          rs_needed = 3'b111;
        end
        FUNCT3_MIN, FUNCT3_MAX, FUNCT3_ROL: begin
          accept    = 1'b1;
          rs_needed = 3'b011;
        end
        FUNCT3_ROLI: begin
          accept    = 1'b1;
          rs_needed = 3'b001;
        end
        default: begin
          accept    = 1'b0;
          rs_needed = 3'b000;
        end
      endcase
    end
  end

  // Unneeded operands count as ready
  assign operands_ready = &(x_q_rs_valid_i | ~rs_needed);
  assign can_push       = operands_ready & ~full_i;

  // Foreign instructions complete at once and never reach the queue
  assign x_q_ready_o     = ~accept | can_push;
  assign x_k_accept_o    = accept;
  assign x_k_writeback_o = accept;

  // Push exactly in the transfer cycle of an accepted instruction
  assign push_valid_o = x_q_valid_i & accept & can_push;
  assign push_instr_o = x_q_instr_data_i;
  assign push_rs_o    = x_q_rs_i;

endmodule

`default_nettype wire

/* xif_pkg.sv */
`default_nettype none

package xif_pkg;

  // Operand width of the integer datapath
  localparam int unsigned DataWidth = 32;

  // Width of a raw instruction word
  localparam int unsigned InstrWidth = 32;

  // Major opcode owned by the accelerator
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // Operation select carried in funct3
  localparam logic [2:0] FUNCT3_ADD3 = 3'd0;
  localparam logic [2:0] FUNCT3_MIN  = 3'd1;
  localparam logic [2:0] FUNCT3_MAX  = 3'd2;
  localparam logic [2:0] FUNCT3_ROL  = 3'd3;
  localparam logic [2:0] FUNCT3_ROLI = 3'd4;

  // Two views of the same instruction word
  typedef union packed {
    // R4 format, used by the three-source add and the register ops
    struct packed {
      logic [4:0] rs3;
      logic [1:0] funct2;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r4;
    // I format, only the immediate rotate
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } xinstr_u;

  // One queue slot holds the instruction word and all three operands
  localparam int unsigned EntryWidth = InstrWidth + 3 * DataWidth;

endpackage

`default_nettype wire
